/* include/board_io_macros.svh */
`ifndef BOARD_IO_MACROS_SVH
`define BOARD_IO_MACROS_SVH

// ====================
// board population.
// ====================
`define BOARD_N_SWITCHES       10
`define BOARD_N_KEYS           2
`define BOARD_N_RED_LEDS       10
`define BOARD_N_DIGITS         6

// synchronized samples that must agree before an input change is taken.
`define BOARD_DEBOUNCE_CYCLES  16

// ====================
// apb register offsets.
// ====================
`define BOARD_ADDR_SWITCHES    8'h00
`define BOARD_ADDR_KEYS        8'h04
`define BOARD_ADDR_RED_LEDS    8'h08
`define BOARD_ADDR_HEX_VALUE   8'h0C
`define BOARD_ADDR_HEX_BLANK   8'h10

`endif

/* design/board_io_regs_pkg.sv */
`include "board_io_macros.svh"

package board_io_regs_pkg;

    // ====================
    // register map.
    // ====================

    // encoding follows the word offset of each register.
    typedef enum logic [2:0] {
        REG_SWITCHES  = 3'd0,
        REG_KEYS      = 3'd1,
        REG_RED_LEDS  = 3'd2,
        REG_HEX_VALUE = 3'd3,
        REG_HEX_BLANK = 3'd4
    } reg_index_t;

    // ====================
    // board samples.
    // ====================
    localparam int DEBOUNCE_CYCLES = `BOARD_DEBOUNCE_CYCLES;

    typedef logic [`BOARD_N_SWITCHES-1:0] switch_sample_t;

    // raw keys are active low on the board.
    typedef logic [`BOARD_N_KEYS-1:0]     key_sample_t;

    typedef logic [`BOARD_N_RED_LEDS-1:0] led_vector_t;

endpackage

/* design/display_pkg.sv */
`include "board_io_macros.svh"

package display_pkg;

    // ====================
    // digit values.
    // ====================
    typedef logic [3:0] hex_nibble_t;

    // ====================
    // segment patterns.
    // ====================

    // active low, bit 0 is segment a and bit 6 is segment g.
    typedef logic [6:0] segment_pattern_t;

    // every segment dark.
    localparam segment_pattern_t SEG_OFF = 7'h7F;

    // ====================
    // blanking.
    // ====================

    // one bit per digit, a set bit turns the digit off.
    typedef logic [`BOARD_N_DIGITS-1:0] digit_blank_t;

endpackage

/* design/input_debouncer.sv */
`timescale 1ns/1ps

module input_debouncer
    import board_io_regs_pkg::*;
#(
    parameter type sample_t      = switch_sample_t,
    parameter int  STABLE_CYCLES = DEBOUNCE_CYCLES
)
(
    input  logic    clk,
    input  logic    rst,
    input  sample_t raw,
    output sample_t clean
);

    localparam int CNT_W = $clog2(STABLE_CYCLES + 1);

    sample_t          sync_q1;
    sample_t          sync_q2;
    logic [CNT_W-1:0] stable_cnt;
    logic             pending;
    logic             settled;

    // a new value is waiting and the synchronizer is not about to move.
    assign pending = (sync_q2 != clean);
    assign settled = (sync_q1 == sync_q2);

    always_ff @(posedge clk) begin
        if (rst) begin
            sync_q1    <= '0;
            sync_q2    <= '0;
            stable_cnt <= '0;
            clean      <= '0;
        end else begin
            sync_q1 <= raw;
            sync_q2 <= sync_q1;

            if (!pending || !settled) begin
                stable_cnt <= '0;
            end else if (stable_cnt == CNT_W'(STABLE_CYCLES - 1)) begin
                clean      <= sync_q2;
                stable_cnt <= '0;
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

    a_cnt_in_range: assert property (
        @(posedge clk) disable iff (rst)
        stable_cnt < CNT_W'(STABLE_CYCLES)
    ) else $error("debounce counter passed its limit");

endmodule

/* design/io_regs_apb.sv */
`timescale 1ns/1ps
`include "board_io_macros.svh"

module io_regs_apb
    import board_io_regs_pkg::*, display_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic [7:0]                   paddr,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [31:0]                  pwdata,
    output logic [31:0]                  prdata,
    output logic                         pready,
    output logic                         pslverr,
    input  switch_sample_t               sw_clean,
    input  key_sample_t                  key_clean,
    output led_vector_t                  ledr,
    output logic [`BOARD_N_DIGITS*4-1:0] hex_value,
    output digit_blank_t                 hex_blank
);

    reg_index_t  reg_idx;
    logic        reg_hit;
    logic        read_only;
    logic        access;
    logic        xfer_err;
    logic        wr_en;
    logic [31:0] rd_data;

    // ====================
    // address decode
    // ====================
    always_comb begin
        reg_hit = 1'b1;
        reg_idx = REG_SWITCHES;
        case (paddr)
            `BOARD_ADDR_SWITCHES:  reg_idx = REG_SWITCHES;
            `BOARD_ADDR_KEYS:      reg_idx = REG_KEYS;
            `BOARD_ADDR_RED_LEDS:  reg_idx = REG_RED_LEDS;
            `BOARD_ADDR_HEX_VALUE: reg_idx = REG_HEX_VALUE;
            `BOARD_ADDR_HEX_BLANK: reg_idx = REG_HEX_BLANK;
            default:               reg_hit = 1'b0;
        endcase
    end

    assign read_only = (reg_idx == REG_SWITCHES) || (reg_idx == REG_KEYS);
    assign access    = psel && penable;
    assign xfer_err  = !reg_hit || (pwrite && read_only);
    assign wr_en     = access && pwrite && !xfer_err;

    // ====================
    // writable registers
    // ====================
    always_ff @(posedge clk) begin
        if (rst) begin
            ledr      <= '0;
            hex_value <= '0;
            hex_blank <= '1;
        end else if (wr_en) begin
            case (reg_idx)
                REG_RED_LEDS:  ledr      <= pwdata[`BOARD_N_RED_LEDS-1:0];
                REG_HEX_VALUE: hex_value <= pwdata[`BOARD_N_DIGITS*4-1:0];
                REG_HEX_BLANK: hex_blank <= pwdata[`BOARD_N_DIGITS-1:0];
                default: ;
            endcase
        end
    end

    // ====================
    // read path
    // ====================
    always_comb begin
        rd_data = '0;
        case (reg_idx)
            REG_SWITCHES:  rd_data[`BOARD_N_SWITCHES-1:0]   = sw_clean;
            // pressed keys pull low, report them as ones.
            REG_KEYS:      rd_data[`BOARD_N_KEYS-1:0]       = ~key_clean;
            REG_RED_LEDS:  rd_data[`BOARD_N_RED_LEDS-1:0]   = ledr;
            REG_HEX_VALUE: rd_data[`BOARD_N_DIGITS*4-1:0]   = hex_value;
            REG_HEX_BLANK: rd_data[`BOARD_N_DIGITS-1:0]     = hex_blank;
            default: ;
        endcase
    end

    // no wait states, so every access cycle completes.
    assign pready  = access;
    assign pslverr = access && xfer_err;
    assign prdata  = (access && !pwrite && !xfer_err) ? rd_data : '0;

    a_penable_in_sel: assert property (
        @(posedge clk) disable iff (rst)
        penable |-> psel
    ) else $error("penable raised outside a selected transfer");

    a_err_no_update: assert property (
        @(posedge clk) disable iff (rst)
        pslverr |=> ($stable(ledr) && $stable(hex_value) && $stable(hex_blank))
    ) else $error("failed transfer changed a register");

endmodule

/* design/seven_segment_driver.sv */
`timescale 1ns/1ps
`include "board_io_macros.svh"

module seven_segment_driver
    import display_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic [`BOARD_N_DIGITS*4-1:0] hex_value,
    input  digit_blank_t                 hex_blank,
    output logic [7:0]                   hex0,
    output logic [7:0]                   hex1,
    output logic [7:0]                   hex2,
    output logic [7:0]                   hex3,
    output logic [7:0]                   hex4,
    output logic [7:0]                   hex5
);

    logic [7:0] digit_q [`BOARD_N_DIGITS];

    function automatic segment_pattern_t glyph(input hex_nibble_t nibble);
        case (nibble)
            4'h0: return 7'h40;
            4'h1: return 7'h79;
            4'h2: return 7'h24;
            4'h3: return 7'h30;
            4'h4: return 7'h19;
            4'h5: return 7'h12;
            4'h6: return 7'h02;
            4'h7: return 7'h78;
            4'h8: return 7'h00;
            4'h9: return 7'h10;
            4'hA: return 7'h08;
            4'hB: return 7'h03;
            4'hC: return 7'h46;
            4'hD: return 7'h21;
            4'hE: return 7'h06;
            default: return 7'h0E;
        endcase
    endfunction

    // ====================
    // per digit decode
    // ====================
    for (genvar i = 0; i < `BOARD_N_DIGITS; i++) begin : g_digit
        hex_nibble_t nibble;

        assign nibble = hex_value[i*4 +: 4];

        // decimal point stays dark.
        always_ff @(posedge clk) begin
            if (rst) begin
                digit_q[i] <= 8'hFF;
            end else if (hex_blank[i]) begin
                digit_q[i] <= {1'b1, SEG_OFF};
            end else begin
                digit_q[i] <= {1'b1, glyph(nibble)};
            end
        end

        a_blank_dark: assert property (
            @(posedge clk) disable iff (rst)
            $past(hex_blank[i]) |-> (digit_q[i] == 8'hFF)
        ) else $error("blanked digit %0d is lit", i);
    end

    assign hex0 = digit_q[0];
    assign hex1 = digit_q[1];
    assign hex2 = digit_q[2];
    assign hex3 = digit_q[3];
    assign hex4 = digit_q[4];
    assign hex5 = digit_q[5];

endmodule

/* design/board_io_top.sv */
`timescale 1ns/1ps

module board_io_top
    import board_io_regs_pkg::*, display_pkg::*;
(
    input  logic           clk,
    input  logic           rst,

    input  logic [7:0]     paddr,
    input  logic           psel,
    input  logic           penable,
    input  logic           pwrite,
    input  logic [31:0]    pwdata,
    output logic [31:0]    prdata,
    output logic           pready,
    output logic           pslverr,

    input  switch_sample_t sw,
    input  key_sample_t    key,
    output led_vector_t    ledr,
    output logic [7:0]     hex0,
    output logic [7:0]     hex1,
    output logic [7:0]     hex2,
    output logic [7:0]     hex3,
    output logic [7:0]     hex4,
    output logic [7:0]     hex5
);

    switch_sample_t                    sw_clean;
    key_sample_t                       key_clean;
    logic [$bits(digit_blank_t)*4-1:0] hex_value;
    digit_blank_t                      hex_blank;

    // ====================
    // board inputs
    // ====================
    input_debouncer #(.sample_t(switch_sample_t)) u_sw_debounce (
        .clk   ( clk      ),
        .rst   ( rst      ),
        .raw   ( sw       ),
        .clean ( sw_clean )
    );

    // keys stay active low here, the register block inverts them.
    input_debouncer #(.sample_t(key_sample_t)) u_key_debounce (
        .clk   ( clk       ),
        .rst   ( rst       ),
        .raw   ( key       ),
        .clean ( key_clean )
    );

    // ====================
    // registers and display
    // ====================
    io_regs_apb u_regs (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .paddr     ( paddr     ),
        .psel      ( psel      ),
        .penable   ( penable   ),
        .pwrite    ( pwrite    ),
        .pwdata    ( pwdata    ),
        .prdata    ( prdata    ),
        .pready    ( pready    ),
        .pslverr   ( pslverr   ),
        .sw_clean  ( sw_clean  ),
        .key_clean ( key_clean ),
        .ledr      ( ledr      ),
        .hex_value ( hex_value ),
        .hex_blank ( hex_blank )
    );

    seven_segment_driver u_display (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .hex_value ( hex_value ),
        .hex_blank ( hex_blank ),
        .hex0      ( hex0      ),
        .hex1      ( hex1      ),
        .hex2      ( hex2      ),
        .hex3      ( hex3      ),
        .hex4      ( hex4      ),
        .hex5      ( hex5      )
    );

endmodule

/* verif/board_io_tb.sv */
`timescale 1ns/1ps
`include "board_io_macros.svh"

module board_io_tb;

    localparam int    CLK_PERIOD = 8;
    localparam string CASE_FILE  = "verif/board_io_cases.txt";

    logic                         clk;
    logic                         rst;
    logic [7:0]                   paddr;
    logic                         psel;
    logic                         penable;
    logic                         pwrite;
    logic [31:0]                  pwdata;
    logic [31:0]                  prdata;
    logic                         pready;
    logic                         pslverr;
    logic [`BOARD_N_SWITCHES-1:0] sw;
    logic [`BOARD_N_KEYS-1:0]     key;
    logic [`BOARD_N_RED_LEDS-1:0] ledr;
    logic [7:0]                   hex_out [`BOARD_N_DIGITS];

    logic [31:0]                  lfsr_state;
    int                           n_cases;
    bit                           cases_counted;

    board_io_top u_dut (
        .clk     ( clk        ),
        .rst     ( rst        ),
        .paddr   ( paddr      ),
        .psel    ( psel       ),
        .penable ( penable    ),
        .pwrite  ( pwrite     ),
        .pwdata  ( pwdata     ),
        .prdata  ( prdata     ),
        .pready  ( pready     ),
        .pslverr ( pslverr    ),
        .sw      ( sw         ),
        .key     ( key        ),
        .ledr    ( ledr       ),
        .hex0    ( hex_out[0] ),
        .hex1    ( hex_out[1] ),
        .hex2    ( hex_out[2] ),
        .hex3    ( hex_out[3] ),
        .hex4    ( hex_out[4] ),
        .hex5    ( hex_out[5] )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ====================
    // helpers
    // ====================
    task automatic stop_run();
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            stop_run();
        end
    endtask

    task automatic check_fields(input string op, input int got, input int want);
        if (got != want) begin
            $display("case line %s has %0d values where %0d are needed", op, got, want);
            stop_run();
        end
    endtask

    function automatic bit is_operation(input byte c);
        return (c == "W") || (c == "R") || (c == "S") || (c == "H") || (c == "L");
    endfunction

    // x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits[i]    = lfsr_state[0];
        end
    endtask

    // setup cycle, access cycle, then back to idle.
    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [31:0] data, output logic [31:0] rdata,
                                output logic err, output logic rdy);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        #(CLK_PERIOD / 4);
        rdata = prdata;
        err   = pslverr;
        rdy   = pready;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // bounce the inputs, then hold the final value until it is accepted.
    task automatic settle_inputs(input logic [31:0] sw_val, input logic [31:0] key_val);
        logic [31:0] bits;
        repeat (4) begin
            @(negedge clk);
            random_bits(`BOARD_N_SWITCHES, bits);
            sw = bits[`BOARD_N_SWITCHES-1:0];
            random_bits(`BOARD_N_KEYS, bits);
            key = bits[`BOARD_N_KEYS-1:0];
        end
        @(negedge clk);
        sw  = sw_val[`BOARD_N_SWITCHES-1:0];
        key = key_val[`BOARD_N_KEYS-1:0];
        repeat (`BOARD_DEBOUNCE_CYCLES + 4) @(negedge clk);
    endtask

    // ====================
    // watchdog
    // ====================
    initial begin
        wait (cases_counted);
        #(n_cases * (`BOARD_DEBOUNCE_CYCLES + 20) * CLK_PERIOD);
        $display("timeout: the case list did not finish in the allowed time");
        stop_run();
    end

    // ====================
    // case runner
    // ====================
    initial begin
        int          fd;
        int          code;
        string       line;
        string       op;
        logic [31:0] arg_a;
        logic [31:0] arg_b;
        logic [31:0] arg_c;
        logic [31:0] exp_hex [`BOARD_N_DIGITS];
        logic [31:0] rdata;
        logic        err;
        logic        rdy;

        rst        = 1'b1;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        sw         = '0;
        key        = '1;
        lfsr_state = 32'h9772ee49;
        n_cases    = 0;

        // count operations first so the watchdog knows the run length.
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("could not open case file %s", CASE_FILE);
            stop_run();
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 0 && is_operation(line[0])) begin
                n_cases++;
            end
        end
        $fclose(fd);
        if (n_cases == 0) begin
            $display("case file %s holds no operations", CASE_FILE);
            stop_run();
        end
        cases_counted = 1'b1;

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        fd = $fopen(CASE_FILE, "r");
        while ($fscanf(fd, "%s", op) == 1) begin
            if (op[0] == "#") begin
                code = $fgets(line, fd);
            end else begin
                case (op)
                    "W": begin
                        code = $fscanf(fd, "%h %h %h", arg_a, arg_b, arg_c);
                        check_fields(op, code, 3);
                        apb_transfer(1'b1, arg_a[7:0], arg_b, rdata, err, rdy);
                        check_value("pready", rdy, 32'h1);
                        check_value("pslverr", err, arg_c);
                        check_value("prdata", rdata, 32'h0);
                    end
                    "R": begin
                        code = $fscanf(fd, "%h %h %h", arg_a, arg_b, arg_c);
                        check_fields(op, code, 3);
                        apb_transfer(1'b0, arg_a[7:0], 32'h0, rdata, err, rdy);
                        check_value("pready", rdy, 32'h1);
                        check_value("pslverr", err, arg_c);
                        check_value("prdata", rdata, arg_b);
                    end
                    "S": begin
                        code = $fscanf(fd, "%h %h", arg_a, arg_b);
                        check_fields(op, code, 2);
                        settle_inputs(arg_a, arg_b);
                    end
                    "H": begin
                        code = $fscanf(fd, "%h %h %h %h %h %h", exp_hex[0], exp_hex[1],
                                       exp_hex[2], exp_hex[3], exp_hex[4], exp_hex[5]);
                        check_fields(op, code, 6);
                        @(negedge clk);
                        for (int i = 0; i < `BOARD_N_DIGITS; i++) begin
                            check_value($sformatf("hex%0d", i), hex_out[i], exp_hex[i]);
                        end
                    end
                    "L": begin
                        code = $fscanf(fd, "%h", arg_a);
                        check_fields(op, code, 1);
                        @(negedge clk);
                        check_value("ledr", ledr, arg_a);
                    end
                    default: begin
                        $display("unknown operation %s in case file", op);
                        stop_run();
                    end
                endcase
            end
        end
        $fclose(fd);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* project.f */
+incdir+include
design/board_io_regs_pkg.sv
design/display_pkg.sv
design/input_debouncer.sv
design/io_regs_apb.sv
design/seven_segment_driver.sv
design/board_io_top.sv
verif/board_io_tb.sv

/* verif/board_io_cases.txt */
# W addr data pslverr | R addr expected_data pslverr | S sw key_raw (keys active low)
# H hex0 .. hex5 expected | L expected ledr | all values in hex
L 000
H FF FF FF FF FF FF
R 08 00000000 0
R 0C 00000000 0
R 00 00000000 0
R 10 0000003F 0
W 08 FFFFF2A5 0
L 2A5
R 08 000002A5 0
W 0C AB543210 0
R 0C 00543210 0
W 10 FFFFFFC0 0
R 10 00000000 0
H C0 F9 A4 B0 99 92
W 0C 00FEDCBA 0
H 88 83 C6 A1 86 8E
W 0C 00987654 0
W 10 00000012 0
H 99 FF 82 F8 FF 90
S 2A5 2
R 00 000002A5 0
R 04 00000001 0
S 15A 0
R 00 0000015A 0
R 04 00000003 0
W 00 FFFFFFFF 1
W 04 00000003 1
W 14 12345678 1
R 14 00000000 1
R 02 00000000 1
R 00 0000015A 0
R 08 000002A5 0
R 0C 00987654 0
R 10 00000012 0
L 2A5
H 99 FF 82 F8 FF 90
